// File: csr_sel_rdata.f
+incdir+design
+incdir+verification
design/csr_rd_pkg.sv
design/csr_counter_rdata.sv
design/csr_mach_rdata.sv
design/csr_sup_rdata.sv
design/csr_sel_rdata.sv
verification/csr_sel_rdata_tb.sv

// File: design/csr_counter_rdata.sv
`timescale 1ns/1ns

`include "csr_rd_macros.svh"

// user counter aliases C00h..C02h and C80h..C82h
module csr_counter_rdata
   import csr_rd_pkg::*;
(
   input  csr_addr_t   csr_addr,
   input  priv_mode_t  mode,
   input  mtime_t      mtime,
   input  mcsr_t       mcsr,
   input  mcsr_t       nxt_mcsr,
   input  scsr_t       scsr,
   output csr_rd_rsp_t part
);

   // alias may be read in the current mode
   logic      av;
   csr_data_t mtime_lo;
   csr_data_t mtime_hi;

   assign mtime_lo = mtime[`CSR_XLEN-1:0];
   assign mtime_hi = mtime[2*`CSR_XLEN-1:`CSR_XLEN];

   // ----------------------------------------
   // privilege gating
   // ----------------------------------------
   // low five address bits pick the enable bit (cy, tm, ir)
   // enables are taken from the committed snapshot only
   always_comb
   begin
      case (mode)
         `CSR_MODE_M:
         begin
            av = 1'b1;
         end
         `CSR_MODE_S:
         begin
            av = mcsr.mcounteren[csr_addr[4:0]];
         end
         `CSR_MODE_U:
         begin
            av = scsr.scounteren[csr_addr[4:0]];
         end
         // reserved mode, never readable
         default:
         begin
            av = 1'b0;
         end
      endcase
   end

   // ----------------------------------------
   // alias decode
   // ----------------------------------------
   always_comb
   begin
      part = '0;
      if (av)
      begin
         case (csr_addr)
            // low halves
            `CSR_A_CYCLE:    part = {1'b1, mcsr.mcycle_lo, nxt_mcsr.mcycle_lo};
            `CSR_A_TIME:     part = {1'b1, mtime_lo, mtime_lo};
            `CSR_A_INSTRET:  part = {1'b1, mcsr.minstret_lo, nxt_mcsr.minstret_lo};
            // high halves, rv32 only
            `CSR_A_CYCLEH:   part = {1'b1, mcsr.mcycle_hi, nxt_mcsr.mcycle_hi};
            // timer has no next value, same word in both fields
            `CSR_A_TIMEH:    part = {1'b1, mtime_hi, mtime_hi};
            `CSR_A_INSTRETH: part = {1'b1, mcsr.minstret_hi, nxt_mcsr.minstret_hi};
            default:         part = '0;
         endcase
      end
   end

endmodule

// File: design/csr_mach_rdata.sv
`timescale 1ns/1ns

`include "csr_rd_macros.svh"

// machine mode register read decode
module csr_mach_rdata
   import csr_rd_pkg::*;
(
   input  csr_addr_t   csr_addr,
   input  mcsr_t       mcsr,
   input  mcsr_t       nxt_mcsr,
   output csr_rd_rsp_t part
);

   // every hit reads in all modes, no gating here
   // each item packs {avail, data, nxt_data}
   always_comb
   begin
      case (csr_addr)
         // ----------------------------------------
         // status, isa, delegation
         // ----------------------------------------
         `CSR_A_MSTATUS:
            part = {1'b1, mcsr.mstatus, nxt_mcsr.mstatus};
         `CSR_A_MISA:
            part = {1'b1, mcsr.misa, nxt_mcsr.misa};
         // delegation always present since s mode exists
         `CSR_A_MEDELEG:
            part = {1'b1, mcsr.medeleg, nxt_mcsr.medeleg};
         `CSR_A_MIDELEG:
            part = {1'b1, mcsr.mideleg, nxt_mcsr.mideleg};

         // interrupt enable and trap vector
         `CSR_A_MIE:
            part = {1'b1, mcsr.mie, nxt_mcsr.mie};
         `CSR_A_MTVEC:
            part = {1'b1, mcsr.mtvec, nxt_mcsr.mtvec};

         // ----------------------------------------
         // counter setup
         // ----------------------------------------
         `CSR_A_MCOUNTEREN:
            part = {1'b1, mcsr.mcounteren, nxt_mcsr.mcounteren};
         `CSR_A_MCOUNTINHIBIT:
            part = {1'b1, mcsr.mcountinhibit, nxt_mcsr.mcountinhibit};

         // ----------------------------------------
         // trap handling
         // ----------------------------------------
         `CSR_A_MSCRATCH:
            part = {1'b1, mcsr.mscratch, nxt_mcsr.mscratch};
         // return address for mret
         `CSR_A_MEPC:
            part = {1'b1, mcsr.mepc, nxt_mcsr.mepc};
         `CSR_A_MCAUSE:
            part = {1'b1, mcsr.mcause, nxt_mcsr.mcause};
         `CSR_A_MTVAL:
            part = {1'b1, mcsr.mtval, nxt_mcsr.mtval};
         `CSR_A_MIP:
            part = {1'b1, mcsr.mip, nxt_mcsr.mip};

         // ----------------------------------------
         // machine counters
         // ----------------------------------------
         `CSR_A_MCYCLE:
            part = {1'b1, mcsr.mcycle_lo, nxt_mcsr.mcycle_lo};
         `CSR_A_MINSTRET:
            part = {1'b1, mcsr.minstret_lo, nxt_mcsr.minstret_lo};
         `CSR_A_MCYCLEH:
            part = {1'b1, mcsr.mcycle_hi, nxt_mcsr.mcycle_hi};
         `CSR_A_MINSTRETH:
            part = {1'b1, mcsr.minstret_hi, nxt_mcsr.minstret_hi};

         // ----------------------------------------
         // id registers, read only
         // ----------------------------------------
         `CSR_A_MVENDORID:
            part = {1'b1, mcsr.mvendorid, nxt_mcsr.mvendorid};
         `CSR_A_MARCHID:
            part = {1'b1, mcsr.marchid, nxt_mcsr.marchid};
         `CSR_A_MIMPID:
            part = {1'b1, mcsr.mimpid, nxt_mcsr.mimpid};
         `CSR_A_MHARTID:
            part = {1'b1, mcsr.mhartid, nxt_mcsr.mhartid};

         // not a machine register, leave to the other decoders
         default:
            part = '0;
      endcase
   end

endmodule

// File: design/csr_rd_macros.svh
`ifndef CSR_RD_MACROS_SVH
`define CSR_RD_MACROS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define CSR_XLEN              32
`define CSR_ADDR_W            12

// privilege mode codes, 2'd2 is reserved
`define CSR_MODE_U            2'd0
`define CSR_MODE_S            2'd1
`define CSR_MODE_M            2'd3

// ----------------------------------------
// machine mode addresses
// ----------------------------------------
`define CSR_A_MSTATUS         12'h300
`define CSR_A_MISA            12'h301
`define CSR_A_MEDELEG         12'h302
`define CSR_A_MIDELEG         12'h303
`define CSR_A_MIE             12'h304
`define CSR_A_MTVEC           12'h305
`define CSR_A_MCOUNTEREN      12'h306
`define CSR_A_MCOUNTINHIBIT   12'h320
`define CSR_A_MSCRATCH        12'h340
`define CSR_A_MEPC            12'h341
`define CSR_A_MCAUSE          12'h342
`define CSR_A_MTVAL           12'h343
`define CSR_A_MIP             12'h344
`define CSR_A_MCYCLE          12'hB00
`define CSR_A_MINSTRET        12'hB02
`define CSR_A_MCYCLEH         12'hB80
`define CSR_A_MINSTRETH       12'hB82
`define CSR_A_MVENDORID       12'hF11
`define CSR_A_MARCHID         12'hF12
`define CSR_A_MIMPID          12'hF13
`define CSR_A_MHARTID         12'hF14

// ----------------------------------------
// supervisor mode addresses
// ----------------------------------------
`define CSR_A_SSTATUS         12'h100
`define CSR_A_SIE             12'h104
`define CSR_A_STVEC           12'h105
`define CSR_A_SCOUNTEREN      12'h106
`define CSR_A_SSCRATCH        12'h140
`define CSR_A_SEPC            12'h141
`define CSR_A_SCAUSE          12'h142
`define CSR_A_STVAL           12'h143
`define CSR_A_SIP             12'h144
`define CSR_A_SATP            12'h180

// user level counter aliases, read only
`define CSR_A_CYCLE           12'hC00
`define CSR_A_TIME            12'hC01
`define CSR_A_INSTRET         12'hC02
`define CSR_A_CYCLEH          12'hC80
`define CSR_A_TIMEH           12'hC81
`define CSR_A_INSTRETH        12'hC82

`endif

// File: design/csr_rd_pkg.sv
`include "csr_rd_macros.svh"

package csr_rd_pkg;

   // ----------------------------------------
   // plain vector types
   // ----------------------------------------
   typedef logic [`CSR_ADDR_W-1:0]   csr_addr_t;
   typedef logic [`CSR_XLEN-1:0]     csr_data_t;
   // 64 bit machine timer, low word in the lower half
   typedef logic [2*`CSR_XLEN-1:0]   mtime_t;
   typedef logic [1:0]               priv_mode_t;

   // ----------------------------------------
   // machine mode register snapshot
   // ----------------------------------------
   typedef struct packed {
      csr_data_t mstatus;
      csr_data_t misa;
      csr_data_t medeleg;
      csr_data_t mideleg;
      csr_data_t mie;
      csr_data_t mtvec;
      // bit n enables the alias at C00h+n for supervisor mode
      csr_data_t mcounteren;
      csr_data_t mcountinhibit;
      csr_data_t mscratch;
      csr_data_t mepc;
      csr_data_t mcause;
      csr_data_t mtval;
      csr_data_t mip;
      // 64 bit counters split in halves
      csr_data_t mcycle_lo;
      csr_data_t mcycle_hi;
      csr_data_t minstret_lo;
      csr_data_t minstret_hi;
      // id registers
      csr_data_t mvendorid;
      csr_data_t marchid;
      csr_data_t mimpid;
      csr_data_t mhartid;
   } mcsr_t;

   // ----------------------------------------
   // supervisor mode register snapshot
   // ----------------------------------------
   typedef struct packed {
      csr_data_t sstatus;
      csr_data_t sie;
      csr_data_t stvec;
      // bit n enables the alias at C00h+n for user mode
      csr_data_t scounteren;
      csr_data_t sscratch;
      csr_data_t sepc;
      csr_data_t scause;
      csr_data_t stval;
      csr_data_t sip;
      csr_data_t satp;
   } scsr_t;

   // read response, also used for each decoder's partial result
   typedef struct packed {
      logic      avail;
      csr_data_t data;
      csr_data_t nxt_data;
   } csr_rd_rsp_t;

endpackage

// File: design/csr_sel_rdata.sv
`timescale 1ns/1ns

// csr read select, one pipeline register after the decoders
module csr_sel_rdata
   import csr_rd_pkg::*;
(
   input  logic        clk_in,
   input  logic        rst_n,
   input  csr_addr_t   csr_addr,
   input  priv_mode_t  mode,
   input  mtime_t      mtime,
   input  mcsr_t       mcsr,
   input  mcsr_t       nxt_mcsr,
   input  scsr_t       scsr,
   input  scsr_t       nxt_scsr,
   output csr_rd_rsp_t rsp
);

   // partial results, zero when the address is not owned
   csr_rd_rsp_t cnt_part;
   csr_rd_rsp_t mach_part;
   csr_rd_rsp_t sup_part;
   csr_rd_rsp_t merged;

   // ----------------------------------------
   // decoders
   // ----------------------------------------
   csr_counter_rdata counter_i (
      .csr_addr (csr_addr),
      .mode     (mode),
      .mtime    (mtime),
      .mcsr     (mcsr),
      .nxt_mcsr (nxt_mcsr),
      .scsr     (scsr),
      .part     (cnt_part)
   );

   csr_mach_rdata mach_i (
      .csr_addr (csr_addr),
      .mcsr     (mcsr),
      .nxt_mcsr (nxt_mcsr),
      .part     (mach_part)
   );

   csr_sup_rdata sup_i (
      .csr_addr (csr_addr),
      .scsr     (scsr),
      .nxt_scsr (nxt_scsr),
      .part     (sup_part)
   );

   // address ranges are disjoint so a plain or is enough
   assign merged = cnt_part | mach_part | sup_part;

   // ----------------------------------------
   // output register
   // ----------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         rsp <= '0;
      end
      else
      begin
         rsp <= merged;
      end
   end

   // ----------------------------------------
   // assertions
   // ----------------------------------------
   // decoders never claim the same address
   a_one_owner : assert property (@(posedge clk_in) disable iff (!rst_n)
      $onehot0({cnt_part.avail, mach_part.avail, sup_part.avail}))
      else $error("more than one csr decoder claimed address %h", csr_addr);

   // a decoder that does not own the address must not leak data into the or
   a_part_zero : assert property (@(posedge clk_in) disable iff (!rst_n)
      (cnt_part.avail || (cnt_part == '0)) &&
      (mach_part.avail || (mach_part == '0)) &&
      (sup_part.avail || (sup_part == '0)))
      else $error("csr partial result with avail low carries data");

   // an unavailable read leaves the stage with zero data
   a_rsp_zero : assert property (@(posedge clk_in) disable iff (!rst_n)
      !rsp.avail |-> (rsp.data == '0) && (rsp.nxt_data == '0))
      else $error("registered csr response with avail low carries data");

endmodule

// File: design/csr_sup_rdata.sv
`timescale 1ns/1ns

`include "csr_rd_macros.svh"

// supervisor mode register read decode
module csr_sup_rdata
   import csr_rd_pkg::*;
(
   input  csr_addr_t   csr_addr,
   input  scsr_t       scsr,
   input  scsr_t       nxt_scsr,
   output csr_rd_rsp_t part
);

   // sedeleg and sideleg (102h, 103h) are not implemented
   // each item packs {avail, data, nxt_data}
   always_comb
   begin
      case (csr_addr)
         // ----------------------------------------
         // status, enables, vector
         // ----------------------------------------
         // restricted view of mstatus
         `CSR_A_SSTATUS:
            part = {1'b1, scsr.sstatus, nxt_scsr.sstatus};
         `CSR_A_SIE:
            part = {1'b1, scsr.sie, nxt_scsr.sie};
         `CSR_A_STVEC:
            part = {1'b1, scsr.stvec, nxt_scsr.stvec};
         // gates the user mode counter aliases
         `CSR_A_SCOUNTEREN:
            part = {1'b1, scsr.scounteren, nxt_scsr.scounteren};

         // ----------------------------------------
         // trap handling
         // ----------------------------------------
         `CSR_A_SSCRATCH:
            part = {1'b1, scsr.sscratch, nxt_scsr.sscratch};
         // return address for sret
         `CSR_A_SEPC:
            part = {1'b1, scsr.sepc, nxt_scsr.sepc};
         `CSR_A_SCAUSE:
            part = {1'b1, scsr.scause, nxt_scsr.scause};
         // faulting address or instruction
         `CSR_A_STVAL:
            part = {1'b1, scsr.stval, nxt_scsr.stval};
         `CSR_A_SIP:
            part = {1'b1, scsr.sip, nxt_scsr.sip};

         // address translation and protection
         `CSR_A_SATP:
            part = {1'b1, scsr.satp, nxt_scsr.satp};

         // not a supervisor register
         default:
            part = '0;
      endcase
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the csr read select testbench with verilator

top=csr_sel_rdata_tb
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f csr_sel_rdata.f --top-module "$top" -Mdir obj_dir -o "$top"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Everything OK$" "$log"; then
   exit 0
else
   echo "pass line not found in $log"
   exit 1
fi

// File: verification/csr_rd_model.svh
`ifndef CSR_RD_MODEL_SVH
`define CSR_RD_MODEL_SVH

`include "csr_rd_macros.svh"

// ----------------------------------------
// address tables
// ----------------------------------------
// machine addresses in mcsr_t field order, msb field first
localparam int n_mach = 21;
localparam csr_addr_t mach_addrs [n_mach] = '{
   `CSR_A_MSTATUS, `CSR_A_MISA, `CSR_A_MEDELEG, `CSR_A_MIDELEG,
   `CSR_A_MIE, `CSR_A_MTVEC, `CSR_A_MCOUNTEREN, `CSR_A_MCOUNTINHIBIT,
   `CSR_A_MSCRATCH, `CSR_A_MEPC, `CSR_A_MCAUSE, `CSR_A_MTVAL, `CSR_A_MIP,
   `CSR_A_MCYCLE, `CSR_A_MCYCLEH, `CSR_A_MINSTRET, `CSR_A_MINSTRETH,
   `CSR_A_MVENDORID, `CSR_A_MARCHID, `CSR_A_MIMPID, `CSR_A_MHARTID
};

// supervisor addresses in scsr_t field order
localparam int n_sup = 10;
localparam csr_addr_t sup_addrs [n_sup] = '{
   `CSR_A_SSTATUS, `CSR_A_SIE, `CSR_A_STVEC, `CSR_A_SCOUNTEREN,
   `CSR_A_SSCRATCH, `CSR_A_SEPC, `CSR_A_SCAUSE, `CSR_A_STVAL, `CSR_A_SIP,
   `CSR_A_SATP
};

// user counter aliases
localparam int n_cnt = 6;
localparam csr_addr_t cnt_addrs [n_cnt] = '{
   `CSR_A_CYCLE, `CSR_A_TIME, `CSR_A_INSTRET,
   `CSR_A_CYCLEH, `CSR_A_TIMEH, `CSR_A_INSTRETH
};

// ----------------------------------------
// expected response for one set of inputs
// ----------------------------------------
function automatic csr_rd_rsp_t model_rsp(
   input csr_addr_t  addr,
   input priv_mode_t md,
   input mtime_t     tm,
   input mcsr_t      m,
   input mcsr_t      nm,
   input scsr_t      s,
   input scsr_t      ns
);
   csr_rd_rsp_t r;
   logic        en;
   logic        hi;
   logic [1:0]  k;
   r = '0;
   // table index picks the word straight out of the packed snapshot
   for (int i = 0; i < n_mach; i++)
   begin
      if (addr == mach_addrs[i])
      begin
         r.avail = 1'b1;
         r.data = m[(n_mach-1-i)*`CSR_XLEN +: `CSR_XLEN];
         r.nxt_data = nm[(n_mach-1-i)*`CSR_XLEN +: `CSR_XLEN];
      end
   end
   for (int i = 0; i < n_sup; i++)
   begin
      if (addr == sup_addrs[i])
      begin
         r.avail = 1'b1;
         r.data = s[(n_sup-1-i)*`CSR_XLEN +: `CSR_XLEN];
         r.nxt_data = ns[(n_sup-1-i)*`CSR_XLEN +: `CSR_XLEN];
      end
   end
   // aliases sit at C00h..C02h, high halves have bit 7 set
   if (addr[11:8] == 4'hC && addr[6:2] == 5'd0 && addr[1:0] != 2'd3)
   begin
      hi = addr[7];
      k = addr[1:0];
      if (md == `CSR_MODE_M)
         en = 1'b1;
      else if (md == `CSR_MODE_S)
         en = m.mcounteren[addr[4:0]];
      else if (md == `CSR_MODE_U)
         en = s.scounteren[addr[4:0]];
      else
         en = 1'b0;
      if (en)
      begin
         r.avail = 1'b1;
         if (k == 2'd1)
         begin
            // timer word goes to both fields
            r.data = hi ? tm[2*`CSR_XLEN-1:`CSR_XLEN] : tm[`CSR_XLEN-1:0];
            r.nxt_data = r.data;
         end
         else if (k == 2'd0)
         begin
            r.data = hi ? m.mcycle_hi : m.mcycle_lo;
            r.nxt_data = hi ? nm.mcycle_hi : nm.mcycle_lo;
         end
         else
         begin
            r.data = hi ? m.minstret_hi : m.minstret_lo;
            r.nxt_data = hi ? nm.minstret_hi : nm.minstret_lo;
         end
      end
   end
   return r;
endfunction

`endif

// File: verification/csr_sel_rdata_tb.sv
`timescale 1ns/1ns

`include "csr_rd_macros.svh"

module csr_sel_rdata_tb
   import csr_rd_pkg::*;
();

   localparam int num_cycles = 2000;

   logic        clk_in;
   logic        rst_n;
   csr_addr_t   csr_addr;
   priv_mode_t  mode;
   mtime_t      mtime;
   mcsr_t       mcsr;
   mcsr_t       nxt_mcsr;
   scsr_t       scsr;
   scsr_t       nxt_scsr;
   csr_rd_rsp_t rsp;
   // response expected after the next rising edge
   csr_rd_rsp_t exp_rsp;
   logic [31:0] rng_state;

   // dropped or unmapped, driven back to back right after reset
   localparam csr_addr_t dropped_addrs [5] = '{12'h000, 12'h102, 12'h3A0, 12'h7B0, 12'hB03};

   `include "csr_rd_model.svh"

   csr_sel_rdata dut_i (
      .clk_in   (clk_in),
      .rst_n    (rst_n),
      .csr_addr (csr_addr),
      .mode     (mode),
      .mtime    (mtime),
      .mcsr     (mcsr),
      .nxt_mcsr (nxt_mcsr),
      .scsr     (scsr),
      .nxt_scsr (nxt_scsr),
      .rsp      (rsp)
   );

   // 100 ns clock
   always #50 clk_in = ~clk_in;

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // index over machine, then supervisor, then alias tables
   function automatic csr_addr_t kept_addr(input int k);
      if (k < n_mach)
         return mach_addrs[k];
      else if (k < n_mach + n_sup)
         return sup_addrs[k-n_mach];
      else
         return cnt_addrs[k-n_mach-n_sup];
   endfunction

   task automatic abort_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s: got %h, expected %h (addr %h, mode %h)",
                  name, got, exp, csr_addr, mode);
         abort_run();
      end
   endtask

   task automatic check_rsp(input csr_rd_rsp_t exp);
      check_val("rsp.avail", 32'(rsp.avail), 32'(exp.avail));
      check_val("rsp.data", rsp.data, exp.data);
      check_val("rsp.nxt_data", rsp.nxt_data, exp.nxt_data);
   endtask

   // new snapshots, mode and address, plus the matching expectation
   task automatic apply_inputs(input int n);
      logic [31:0] r;
      int          pick;
      for (int i = 0; i < n_mach; i++)
      begin
         mcsr[i*`CSR_XLEN +: `CSR_XLEN] = next_rand();
         nxt_mcsr[i*`CSR_XLEN +: `CSR_XLEN] = next_rand();
      end
      for (int i = 0; i < n_sup; i++)
      begin
         scsr[i*`CSR_XLEN +: `CSR_XLEN] = next_rand();
         nxt_scsr[i*`CSR_XLEN +: `CSR_XLEN] = next_rand();
      end
      mtime = {next_rand(), next_rand()};
      r = next_rand();
      // all four codes, reserved one included
      mode = r[1:0];
      r = next_rand();
      pick = int'(r[15:1]) % (n_mach + n_sup + n_cnt);
      if (n < 5)
         csr_addr = dropped_addrs[n];
      else if (r[0])
         csr_addr = kept_addr(pick);
      else
         csr_addr = r[27:16];
      exp_rsp = model_rsp(csr_addr, mode, mtime, mcsr, nxt_mcsr, scsr, nxt_scsr);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial
   begin
      rng_state = 32'd27;
      clk_in = 1'b0;
      rst_n = 1'b0;
      apply_inputs(num_cycles);
      // a readable register during reset must not reach rsp
      csr_addr = `CSR_A_MSTATUS;
      mode = `CSR_MODE_M;
      // reset held for two cycles
      repeat (2) @(negedge clk_in);
      // release, output still holds the cleared value
      check_rsp('0);
      rst_n = 1'b1;
      apply_inputs(0);
      for (int n = 1; n < num_cycles; n++)
      begin
         @(negedge clk_in);
         check_rsp(exp_rsp);
         apply_inputs(n);
      end
      @(negedge clk_in);
      check_rsp(exp_rsp);
      $display("Everything OK");
      $finish;
   end

endmodule
